// ==== Makefile ====
# Verilator build and run for the systolic matrix-vector engine.

VERILATOR ?= verilator
TOP       ?= sa_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 4

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output.
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^SIMULATION PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/sa_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_tb;

    localparam int HEIGHT = sa_pkg::SA_HEIGHT;
    localparam int WIDTH = sa_pkg::SA_WIDTH;
    localparam int IWIDTH = sa_pkg::SA_IWIDTH;
    localparam int OWIDTH = sa_pkg::SA_OWIDTH;
    localparam int DEPTH = sa_pkg::SA_DEPTH;
    localparam int TIMEOUT_CYCLES = 12000;  // 300 rows at up to 40 cycles each.
    localparam int STREAM_LEN = 200;

    logic                     clk;
    logic                     reset_i;
    logic                     in_req_i;
    logic                     in_ack_o;
    sa_pkg::sa_kind_e         in_kind_i;
    logic [HEIGHT*IWIDTH-1:0] in_data_i;
    logic                     out_req_o;
    logic                     out_ack_i;
    logic [WIDTH*OWIDTH-1:0]  out_data_o;

    logic signed [IWIDTH-1:0] wgt_model [HEIGHT][WIDTH];
    logic [WIDTH*OWIDTH-1:0]  exp_q [$];
    int mismatch_count = 0;
    int fail_count = 0;
    int sent = 0;
    int received = 0;
    int ack_wait = 0;
    int cycle_count = 0;

    sa_top #(
        .HEIGHT(HEIGHT),
        .WIDTH(WIDTH),
        .IWIDTH(IWIDTH),
        .OWIDTH(OWIDTH),
        .DEPTH(DEPTH)
    ) uut (
        .clk(clk),
        .reset_i(reset_i),
        .in_req_i(in_req_i),
        .in_ack_o(in_ack_o),
        .in_kind_i(in_kind_i),
        .in_data_i(in_data_i),
        .out_req_o(out_req_o),
        .out_ack_i(out_ack_i),
        .out_data_o(out_data_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ****************************************
    // reference model.
    // ****************************************

    function automatic logic [WIDTH*OWIDTH-1:0] expect_result(input logic [HEIGHT*IWIDTH-1:0] x);
        logic [WIDTH*OWIDTH-1:0]  r;
        logic signed [OWIDTH-1:0] acc;
        logic signed [IWIDTH-1:0] xe;
        r = '0;
        for (int w = 0; w < WIDTH; w++) begin
            acc = '0;
            for (int h = 0; h < HEIGHT; h++) begin
                xe = x[h*IWIDTH +: IWIDTH];
                acc = acc + OWIDTH'(xe) * OWIDTH'(wgt_model[h][w]);
            end
            r[w*OWIDTH +: OWIDTH] = acc;
        end
        return r;
    endfunction

    // each push moves every column down one row.
    task automatic shift_weight_model(input logic [HEIGHT*IWIDTH-1:0] d);
        for (int h = HEIGHT - 1; h > 0; h--) begin
            for (int w = 0; w < WIDTH; w++) begin
                wgt_model[h][w] = wgt_model[h-1][w];
            end
        end
        for (int w = 0; w < WIDTH; w++) begin
            wgt_model[0][w] = d[w*IWIDTH +: IWIDTH];
        end
    endtask

    function automatic logic [HEIGHT*IWIDTH-1:0] random_row();
        logic [HEIGHT*IWIDTH-1:0] r;
        for (int h = 0; h < HEIGHT; h++) begin
            r[h*IWIDTH +: IWIDTH] = IWIDTH'($urandom);
        end
        return r;
    endfunction

    function automatic logic [HEIGHT*IWIDTH-1:0] fill_row(input logic [IWIDTH-1:0] v);
        logic [HEIGHT*IWIDTH-1:0] r;
        for (int h = 0; h < HEIGHT; h++) begin
            r[h*IWIDTH +: IWIDTH] = v;
        end
        return r;
    endfunction

    // ****************************************
    // input and output handshakes.
    // ****************************************

    task automatic send_row(input sa_pkg::sa_kind_e kind, input logic [HEIGHT*IWIDTH-1:0] data);
        @(posedge clk);
        in_req_i <= 1'b1;
        in_kind_i <= kind;
        in_data_i <= data;
        ack_wait = 0;
        do begin
            @(negedge clk);
            ack_wait++;
        end while (!in_ack_o);
        if (kind == sa_pkg::SA_WGT) begin
            shift_weight_model(data);
        end else begin
            exp_q.push_back(expect_result(data));  // the model sees rows in ack order.
            sent++;
        end
        @(posedge clk);
        in_req_i <= 1'b0;
        do @(negedge clk); while (in_ack_o);
    endtask

    task automatic load_weights(input logic random_fill, input logic [IWIDTH-1:0] v);
        repeat (HEIGHT) send_row(sa_pkg::SA_WGT, random_fill ? random_row() : fill_row(v));
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    initial begin : receiver
        logic [WIDTH*OWIDTH-1:0] exp_vec;
        int delay;
        out_ack_i <= 1'b0;
        forever begin
            @(negedge clk);
            if (out_req_o) begin
                assert (exp_q.size() != 0) else begin
                    fail_count++;
                    $display("%0t: a result came out with no vector outstanding", $time);
                end
                if (exp_q.size() != 0) begin
                    exp_vec = exp_q.pop_front();
                    received++;
                    assert (out_data_o == exp_vec) else begin
                        mismatch_count++;
                        $display("Mismatch at %0t: out_data_o expected %h, got %h",
                                 $time, exp_vec, out_data_o);
                    end
                end
                delay = $urandom_range(0, 6);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                out_ack_i <= 1'b1;
                do @(negedge clk); while (out_req_o);
                @(posedge clk);
                out_ack_i <= 1'b0;
            end
        end
    end

    // ****************************************
    // protocol assertions.
    // ****************************************

    a_reset_idle : assert property (@(posedge clk) reset_i |=> !in_ack_o && !out_req_o) else begin
        fail_count++;
        $display("%0t: a handshake output was high during or just after reset", $time);
    end

    a_out_stable : assert property (
        @(posedge clk) disable iff (reset_i)
        (out_req_o && !out_ack_i) |=> $stable(out_data_o)
    ) else begin
        fail_count++;
        $display("%0t: out_data_o changed while waiting for out_ack_i", $time);
    end

    a_out_req_rise : assert property (
        @(posedge clk) disable iff (reset_i)
        (out_ack_i && !out_req_o) |=> !out_req_o
    ) else begin
        fail_count++;
        $display("%0t: out_req_o rose while out_ack_i was still high", $time);
    end

    a_in_ack_rise : assert property (
        @(posedge clk) disable iff (reset_i)
        (!in_req_i && !in_ack_o) |=> !in_ack_o
    ) else begin
        fail_count++;
        $display("%0t: in_ack_o rose with in_req_i low", $time);
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ****************************************
    // test sequence.
    // ****************************************

    initial begin : stimulus
        void'($urandom(32'hce8a7cea));
        reset_i <= 1'b1;
        in_req_i <= 1'b0;
        in_kind_i <= sa_pkg::SA_ACT;
        in_data_i <= '0;
        for (int h = 0; h < HEIGHT; h++) begin
            for (int w = 0; w < WIDTH; w++) begin
                wgt_model[h][w] = '0;
            end
        end
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;

        load_weights(1'b1, '0);
        send_row(sa_pkg::SA_ACT, random_row());
        wait_results();

        repeat (STREAM_LEN) begin
            send_row(sa_pkg::SA_ACT, random_row());
            repeat ($urandom_range(0, 2)) @(posedge clk);
        end

        // reload right behind a burst, so the first weight row has to wait.
        repeat (6) send_row(sa_pkg::SA_ACT, random_row());
        send_row(sa_pkg::SA_WGT, random_row());
        assert (ack_wait > 2) else begin
            fail_count++;
            $display("%0t: weight row was taken with vectors still in flight", $time);
        end
        repeat (HEIGHT - 1) send_row(sa_pkg::SA_WGT, random_row());
        repeat (6) send_row(sa_pkg::SA_ACT, random_row());
        wait_results();

        load_weights(1'b0, 8'h80);
        send_row(sa_pkg::SA_ACT, fill_row(8'h80));
        send_row(sa_pkg::SA_ACT, fill_row(8'h7f));
        load_weights(1'b0, 8'h7f);
        send_row(sa_pkg::SA_ACT, fill_row(8'h80));
        send_row(sa_pkg::SA_ACT, fill_row(8'h7f));
        wait_results();
        repeat (4) @(posedge clk);

        $display("results %0d of %0d, mismatches %0d, other errors %0d",
                 received, sent, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/sa_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_array #(
    parameter int HEIGHT = sa_pkg::SA_HEIGHT,
    parameter int WIDTH = sa_pkg::SA_WIDTH,
    parameter int IWIDTH = sa_pkg::SA_IWIDTH,
    parameter int OWIDTH = sa_pkg::SA_OWIDTH
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic [HEIGHT-1:0]         act_en_i,
    input  logic [HEIGHT*IWIDTH-1:0]  act_col_i,
    input  logic                      wgt_en_i,
    input  logic [WIDTH*IWIDTH-1:0]   wgt_row_i,
    output logic [WIDTH-1:0]          sum_en_o,
    output logic [WIDTH*OWIDTH-1:0]   sum_row_o
);

    // activations run along rows, weights and sums along columns.
    // sum index HEIGHT is the zero feed below the bottom row.
    logic                     act_en_x [HEIGHT][WIDTH+1];
    logic signed [IWIDTH-1:0] act_x    [HEIGHT][WIDTH+1];
    logic                     wgt_en_x [HEIGHT+1][WIDTH];
    logic signed [IWIDTH-1:0] wgt_x    [HEIGHT+1][WIDTH];
    logic                     sum_en_x [HEIGHT+1][WIDTH];
    logic signed [OWIDTH-1:0] sum_x    [HEIGHT+1][WIDTH];

    // ****************************************
    // edges of the grid.
    // ****************************************

    for (genvar h = 0; h < HEIGHT; h++) begin : g_left
        assign act_en_x[h][0] = act_en_i[h];
        assign act_x[h][0] = act_col_i[h*IWIDTH +: IWIDTH];
    end

    for (genvar w = 0; w < WIDTH; w++) begin : g_edge
        assign wgt_en_x[0][w] = wgt_en_i;
        assign wgt_x[0][w] = wgt_row_i[w*IWIDTH +: IWIDTH];

        // the bottom sum starts when the bottom row's activation reaches this column.
        assign sum_en_x[HEIGHT][w] = act_en_x[HEIGHT-1][w];
        assign sum_x[HEIGHT][w] = '0;

        assign sum_en_o[w] = sum_en_x[0][w];
        assign sum_row_o[w*OWIDTH +: OWIDTH] = sum_x[0][w];
    end

    // ****************************************
    // cell grid.
    // ****************************************

    for (genvar h = 0; h < HEIGHT; h++) begin : g_row
        for (genvar w = 0; w < WIDTH; w++) begin : g_col
            sa_pe #(
                .IWIDTH(IWIDTH),
                .OWIDTH(OWIDTH)
            ) u_pe (
                .clk(clk),
                .reset_i(reset_i),
                .act_en_i(act_en_x[h][w]),
                .act_i(act_x[h][w]),
                .act_en_o(act_en_x[h][w+1]),
                .act_o(act_x[h][w+1]),
                .wgt_en_i(wgt_en_x[h][w]),
                .wgt_i(wgt_x[h][w]),
                .wgt_en_o(wgt_en_x[h+1][w]),
                .wgt_o(wgt_x[h+1][w]),
                .sum_en_i(sum_en_x[h+1][w]),
                .sum_i(sum_x[h+1][w]),
                .sum_en_o(sum_en_x[h][w]),
                .sum_o(sum_x[h][w])
            );
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sa_in_skew.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_in_skew #(
    parameter int HEIGHT = sa_pkg::SA_HEIGHT,
    parameter int WIDTH = sa_pkg::SA_WIDTH,
    parameter int IWIDTH = sa_pkg::SA_IWIDTH,
    parameter int DEPTH = sa_pkg::SA_DEPTH
) (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         in_req_i,
    input  sa_pkg::sa_kind_e             in_kind_i,
    input  logic [HEIGHT*IWIDTH-1:0]     in_data_i,
    output logic                         in_ack_o,
    input  logic [$clog2(DEPTH+1)-1:0]   slot_free_i,
    output logic                         wgt_en_o,
    output logic [WIDTH*IWIDTH-1:0]      wgt_row_o,
    output logic [HEIGHT-1:0]            act_en_o,
    output logic [HEIGHT*IWIDTH-1:0]     act_col_o
);

    localparam int CW = $clog2(DEPTH + 1);

    logic [CW-1:0]           in_flight;
    logic [CW-1:0]           slot_free_q;
    logic                    is_wgt;
    logic                    can_take;
    logic                    take;
    logic                    act_take;
    logic                    retire;
    logic                    wgt_take_q;
    logic [WIDTH*IWIDTH-1:0] wgt_hold_q;

    // a weight row waits until the array and deskew hold no activations.
    assign is_wgt = (in_kind_i == sa_pkg::SA_WGT);
    assign can_take = is_wgt ? (in_flight == '0) : (in_flight < slot_free_i);
    assign take = in_req_i && !in_ack_o && can_take;
    assign act_take = take && !is_wgt;
    assign retire = (slot_free_i < slot_free_q);  // a vector was written into the buffer.

    // ****************************************
    // four-phase input handshake.
    // ****************************************

    always_ff @(posedge clk) begin
        if (reset_i) begin
            in_ack_o <= 1'b0;
        end else if (take) begin
            in_ack_o <= 1'b1;
        end else if (!in_req_i) begin
            in_ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        slot_free_q <= slot_free_i;
        if (reset_i) begin
            in_flight <= '0;
        end else if (act_take && !retire) begin
            in_flight <= in_flight + 1'b1;
        end else if (retire && !act_take) begin
            in_flight <= in_flight - 1'b1;
        end
    end

    // weight rows use the low WIDTH elements, so WIDTH may not exceed HEIGHT.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wgt_take_q <= 1'b0;
            wgt_en_o <= 1'b0;
        end else begin
            wgt_take_q <= take && is_wgt;
            wgt_en_o <= wgt_take_q;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wgt_hold_q <= in_data_i[WIDTH*IWIDTH-1:0];
        end
        wgt_row_o <= wgt_hold_q;
    end

    // ****************************************
    // triangular activation skew.
    // ****************************************

    for (genvar h = 0; h < HEIGHT; h++) begin : g_skew
        localparam int N = HEIGHT - h;  // the first stage loads on the accept edge.

        logic [N-1:0]      en_q;
        logic [IWIDTH-1:0] dat_q [N];

        always_ff @(posedge clk) begin
            if (reset_i) begin
                en_q <= '0;
            end else begin
                en_q[0] <= act_take;
                for (int i = 1; i < N; i++) begin
                    en_q[i] <= en_q[i-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (act_take) begin
                dat_q[0] <= in_data_i[h*IWIDTH +: IWIDTH];
            end
            for (int i = 1; i < N; i++) begin
                dat_q[i] <= dat_q[i-1];
            end
        end

        assign act_en_o[h] = en_q[N-1];
        assign act_col_o[h*IWIDTH +: IWIDTH] = dat_q[N-1];
    end

    a_in_stable : assert property (
        @(posedge clk) disable iff (reset_i)
        (in_req_i && !in_ack_o) ##1 in_req_i |-> $stable(in_data_i) && $stable(in_kind_i)
    );

    // old and new weights must never meet the same vector.
    a_wgt_idle : assert property (
        @(posedge clk) disable iff (reset_i)
        wgt_en_o |-> (in_flight == '0)
    );

endmodule

`default_nettype wire

// ==== rtl/sa_out_deskew.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_out_deskew #(
    parameter int WIDTH = sa_pkg::SA_WIDTH,
    parameter int OWIDTH = sa_pkg::SA_OWIDTH,
    parameter int DEPTH = sa_pkg::SA_DEPTH
) (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic [WIDTH-1:0]             sum_en_i,
    input  logic [WIDTH*OWIDTH-1:0]      sum_row_i,
    output logic [$clog2(DEPTH+1)-1:0]   slot_free_o,
    output logic                         out_req_o,
    input  logic                         out_ack_i,
    output logic [WIDTH*OWIDTH-1:0]      out_data_o
);

    localparam int CW = $clog2(DEPTH + 1);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int VW = WIDTH * OWIDTH;

    logic [WIDTH-1:0] al_en;
    logic [VW-1:0]    al_row;
    logic [VW-1:0]    mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             wr_en;
    logic             pop;

    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ****************************************
    // column deskew.
    // ****************************************

    for (genvar w = 0; w < WIDTH; w++) begin : g_col
        localparam int N = WIDTH - 1 - w;  // column 0 leaves the array first.

        if (N == 0) begin : g_pass
            assign al_en[w] = sum_en_i[w];
            assign al_row[w*OWIDTH +: OWIDTH] = sum_row_i[w*OWIDTH +: OWIDTH];
        end else begin : g_dly
            logic [N-1:0]      en_q;
            logic [OWIDTH-1:0] dat_q [N];

            always_ff @(posedge clk) begin
                if (reset_i) begin
                    en_q <= '0;
                end else begin
                    en_q[0] <= sum_en_i[w];
                    for (int i = 1; i < N; i++) begin
                        en_q[i] <= en_q[i-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                dat_q[0] <= sum_row_i[w*OWIDTH +: OWIDTH];
                for (int i = 1; i < N; i++) begin
                    dat_q[i] <= dat_q[i-1];
                end
            end

            assign al_en[w] = en_q[N-1];
            assign al_row[w*OWIDTH +: OWIDTH] = dat_q[N-1];
        end
    end

    // ****************************************
    // result buffer and output handshake.
    // ****************************************

    assign wr_en = al_en[0];
    // a read waits out a write cycle, so slot_free_o moves by one step at a time.
    assign pop = !out_req_o && !out_ack_i && (count != '0) && !wr_en;
    assign slot_free_o = CW'(DEPTH) - count;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= al_row;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            out_req_o <= 1'b0;
            out_data_o <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_next(wr_ptr);
                count <= count + 1'b1;
            end else if (pop) begin
                count <= count - 1'b1;
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
                out_data_o <= mem[rd_ptr];
                out_req_o <= 1'b1;
            end else if (out_req_o && out_ack_i) begin
                out_req_o <= 1'b0;  // ack must fall again before the next request.
            end
        end
    end

    // every column of a vector has to arrive in the same aligned cycle.
    a_cols_aligned : assert property (
        @(posedge clk) disable iff (reset_i)
        wr_en |-> (&al_en)
    );

    a_no_overflow : assert property (
        @(posedge clk) disable iff (reset_i)
        wr_en |-> (count < CW'(DEPTH))
    );

endmodule

`default_nettype wire

// ==== rtl/sa_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_pe #(
    parameter int IWIDTH = sa_pkg::SA_IWIDTH,
    parameter int OWIDTH = sa_pkg::SA_OWIDTH
) (
    input  logic                     clk,
    input  logic                     reset_i,

    input  logic                     act_en_i,
    input  logic signed [IWIDTH-1:0] act_i,
    output logic                     act_en_o,
    output logic signed [IWIDTH-1:0] act_o,

    input  logic                     wgt_en_i,
    input  logic signed [IWIDTH-1:0] wgt_i,
    output logic                     wgt_en_o,
    output logic signed [IWIDTH-1:0] wgt_o,

    input  logic                     sum_en_i,
    input  logic signed [OWIDTH-1:0] sum_i,
    output logic                     sum_en_o,
    output logic signed [OWIDTH-1:0] sum_o
);

    logic signed [IWIDTH-1:0]   wgt_q;
    logic signed [2*IWIDTH-1:0] prod;

    assign prod = act_i * wgt_q;

    // the push enable is shared by a whole column, so every row shifts on one load.
    assign wgt_en_o = wgt_en_i;
    assign wgt_o = wgt_q;  // the old weight moves down as the new one comes in.

    always_ff @(posedge clk) begin
        if (reset_i) begin
            act_en_o <= 1'b0;
            sum_en_o <= 1'b0;
            sum_o <= '0;
            wgt_q <= '0;
        end else begin
            act_en_o <= act_en_i;
            sum_en_o <= sum_en_i;
            if (wgt_en_i) begin
                wgt_q <= wgt_i;
            end
            if (sum_en_i) begin
                sum_o <= sum_i + prod;  // product is sign extended to the sum width.
            end
        end
    end

    always_ff @(posedge clk) begin
        act_o <= act_i;
    end

    // the input skew has to line each activation up with the sum climbing past it.
    a_sum_meets_act : assert property (
        @(posedge clk) disable iff (reset_i)
        sum_en_i == act_en_i
    );

endmodule

`default_nettype wire

// ==== rtl/sa_pkg.sv ====
`default_nettype none

package sa_pkg;

    // ****************************************
    // default geometry and number formats.
    // ****************************************

    localparam int SA_HEIGHT = 4;  // array rows, also the activation vector length.
    localparam int SA_WIDTH = 4;   // array columns, also the result vector length.
    localparam int SA_IWIDTH = 8;  // signed weight and activation width.
    localparam int SA_OWIDTH = 24; // signed partial sum width.
    localparam int SA_DEPTH = 4;   // result buffer slots in the output stage.

    // what a row on the input handshake carries.
    typedef enum logic {
        SA_ACT = 1'b0,  // an activation vector.
        SA_WGT = 1'b1   // one row of weights.
    } sa_kind_e;

endpackage

`default_nettype wire

// ==== rtl/sa_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_top #(
    parameter int HEIGHT = sa_pkg::SA_HEIGHT,
    parameter int WIDTH = sa_pkg::SA_WIDTH,
    parameter int IWIDTH = sa_pkg::SA_IWIDTH,
    parameter int OWIDTH = sa_pkg::SA_OWIDTH,
    parameter int DEPTH = sa_pkg::SA_DEPTH
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       in_req_i,
    output logic                       in_ack_o,
    input  sa_pkg::sa_kind_e           in_kind_i,
    input  logic [HEIGHT*IWIDTH-1:0]   in_data_i,
    output logic                       out_req_o,
    input  logic                       out_ack_i,
    output logic [WIDTH*OWIDTH-1:0]    out_data_o
);

    logic                         wgt_en;
    logic [WIDTH*IWIDTH-1:0]      wgt_row;
    logic [HEIGHT-1:0]            act_en;
    logic [HEIGHT*IWIDTH-1:0]     act_col;
    logic [WIDTH-1:0]             sum_en;
    logic [WIDTH*OWIDTH-1:0]      sum_row;
    logic [$clog2(DEPTH+1)-1:0]   slot_free;

    sa_in_skew #(
        .HEIGHT(HEIGHT),
        .WIDTH(WIDTH),
        .IWIDTH(IWIDTH),
        .DEPTH(DEPTH)
    ) u_in_skew (
        .clk(clk),
        .reset_i(reset_i),
        .in_req_i(in_req_i),
        .in_kind_i(in_kind_i),
        .in_data_i(in_data_i),
        .in_ack_o(in_ack_o),
        .slot_free_i(slot_free),
        .wgt_en_o(wgt_en),
        .wgt_row_o(wgt_row),
        .act_en_o(act_en),
        .act_col_o(act_col)
    );

    sa_array #(
        .HEIGHT(HEIGHT),
        .WIDTH(WIDTH),
        .IWIDTH(IWIDTH),
        .OWIDTH(OWIDTH)
    ) u_array (
        .clk(clk),
        .reset_i(reset_i),
        .act_en_i(act_en),
        .act_col_i(act_col),
        .wgt_en_i(wgt_en),
        .wgt_row_i(wgt_row),
        .sum_en_o(sum_en),
        .sum_row_o(sum_row)
    );

    sa_out_deskew #(
        .WIDTH(WIDTH),
        .OWIDTH(OWIDTH),
        .DEPTH(DEPTH)
    ) u_out_deskew (
        .clk(clk),
        .reset_i(reset_i),
        .sum_en_i(sum_en),
        .sum_row_i(sum_row),
        .slot_free_o(slot_free),
        .out_req_o(out_req_o),
        .out_ack_i(out_ack_i),
        .out_data_o(out_data_o)
    );

endmodule

`default_nettype wire

// ==== src.f ====
rtl/sa_pkg.sv
rtl/sa_pe.sv
rtl/sa_array.sv
rtl/sa_in_skew.sv
rtl/sa_out_deskew.sv
rtl/sa_top.sv
dv/sa_tb.sv
